//--- design/vseq_cfg.svh
// Configuration macros of the vector sequencer
// Size of the instruction ID pool, the register file and the
// queue depth of each functional unit
`ifndef VSEQ_CFG_SVH
`define VSEQ_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Instruction pool and register file
////////////////////////////////////////////////////////////////////////////

// Instructions in flight, one ID each
`define VSEQ_NR_IDS 4

// Architectural vector registers
`define VSEQ_NR_VREGS 32

////////////////////////////////////////////////////////////////////////////
// Queue depth per functional unit
////////////////////////////////////////////////////////////////////////////

// Counters are 2 bits wide, so no depth may exceed 3
`define VSEQ_DEPTH_ALU 2
`define VSEQ_DEPTH_MUL 2
`define VSEQ_DEPTH_LOAD 1
`define VSEQ_DEPTH_STORE 1

`endif

//--- design/vseq_pkg.sv
// Shared types of the vector sequencer
// Instruction IDs and ID masks, register indices, the unit
// encoding, unit masks and queue counters
`include "vseq_cfg.svh"

package vseq_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction IDs
  ////////////////////////////////////////////////////////////////////////////

  // Index into the ID pool
  typedef logic [$clog2(`VSEQ_NR_IDS)-1:0] vid_t;

  // One bit per ID, for the running set and hazard vectors
  typedef logic [`VSEQ_NR_IDS-1:0] id_mask_t;

  ////////////////////////////////////////////////////////////////////////////
  // Registers and units
  ////////////////////////////////////////////////////////////////////////////

  // Vector register index
  typedef logic [4:0] vreg_t;

  // Number of functional units behind the sequencer
  localparam int unsigned nr_units = 4;

  // Target unit of an instruction
  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_MUL   = 2'd1,
    UNIT_LOAD  = 2'd2,
    UNIT_STORE = 2'd3
  } unit_e;

  // One bit per unit, indexed by unit_e
  typedef logic [nr_units-1:0] unit_mask_t;

  // Queue occupancy, wide enough for the deepest queue
  typedef logic [1:0] credit_cnt_t;

endpackage : vseq_pkg

//--- design/insn_intake.sv
// Dispatcher side of the sequencer
// Four-phase receiver holding one instruction until it issues,
// then completing the ack phases toward the dispatcher
`timescale 1ns/100ps

module insn_intake import vseq_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  // Dispatcher handshake
  input  logic  disp_req_i,
  input  unit_e disp_unit_i,
  input  vreg_t disp_vd_i,
  input  vreg_t disp_vs1_i,
  input  vreg_t disp_vs2_i,
  input  logic  disp_use_vd_i,
  input  logic  disp_use_vs1_i,
  input  logic  disp_use_vs2_i,
  output logic  disp_ack_o,
  // Issue decision from the tracker
  input  logic  issue_fire_i,
  // Held instruction
  output logic  insn_valid_o,
  output unit_e insn_unit_o,
  output vreg_t insn_vd_o,
  output vreg_t insn_vs1_o,
  output vreg_t insn_vs2_o,
  output logic  insn_use_vd_o,
  output logic  insn_use_vs1_o,
  output logic  insn_use_vs2_o
);

  // Empty, holding an unissued instruction, or acking the dispatcher
  typedef enum logic [1:0] {
    ST_EMPTY,
    ST_HELD,
    ST_ACKED
  } intake_state_e;

  intake_state_e state_q, state_d;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // Capture on the first sampled req
      ST_EMPTY: if (disp_req_i) state_d = ST_HELD;
      // Stay until the tracker issues it
      ST_HELD:  if (issue_fire_i) state_d = ST_ACKED;
      // Ack drops one cycle after req is seen low
      ST_ACKED: if (!disp_req_i) state_d = ST_EMPTY;
      default:  state_d = ST_EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // Instruction fields, loaded once per handshake
  always_ff @(posedge clk_i) begin
    if (state_q == ST_EMPTY && disp_req_i) begin
      insn_unit_o    <= disp_unit_i;
      insn_vd_o      <= disp_vd_i;
      insn_vs1_o     <= disp_vs1_i;
      insn_vs2_o     <= disp_vs2_i;
      insn_use_vd_o  <= disp_use_vd_i;
      insn_use_vs1_o <= disp_use_vs1_i;
      insn_use_vs2_o <= disp_use_vs2_i;
    end
  end

  assign insn_valid_o = (state_q == ST_HELD);
  assign disp_ack_o   = (state_q == ST_ACKED);

  // Tracker only issues what the intake presents
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_fire_i |-> insn_valid_o);

endmodule : insn_intake

//--- design/hazard_tracker.sv
// Dependency tracking and issue decision
// Running set and lowest-free ID allocation, per-register reader
// and writer lists, hazard vectors, completion bookkeeping
`timescale 1ns/100ps
`include "vseq_cfg.svh"

module hazard_tracker import vseq_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Held instruction from the intake
  input  logic       insn_valid_i,
  input  unit_e      insn_unit_i,
  input  vreg_t      insn_vd_i,
  input  vreg_t      insn_vs1_i,
  input  vreg_t      insn_vs2_i,
  input  logic       insn_use_vd_i,
  input  logic       insn_use_vs1_i,
  input  logic       insn_use_vs2_i,
  // Readiness of the queues and the output port
  input  unit_mask_t unit_ready_i,
  input  logic       port_free_i,
  // Completion from the units
  input  logic       done_valid_i,
  input  vid_t       done_id_i,
  // Issue toward credits and port
  output logic       issue_fire_o,
  output unit_e      issue_unit_o,
  output vid_t       issue_id_o,
  output id_mask_t   issue_hazard_o,
  // Completion toward credits
  output logic       done_fire_o,
  output unit_e      done_unit_o,
  output logic       idle_o
);

  // Last reader or writer of a register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  id_mask_t running_q, running_d;
  id_mask_t done_mask, live_mask;
  unit_e    unit_q [`VSEQ_NR_IDS];
  vid_t     free_id;
  logic     free_found;
  id_mask_t hazard;

  vreg_access_t [`VSEQ_NR_VREGS-1:0] read_list_q, read_list_d;
  vreg_access_t [`VSEQ_NR_VREGS-1:0] write_list_q, write_list_d;

  ////////////////////////////////////////////////////////////////////////////
  // Running set and allocation
  ////////////////////////////////////////////////////////////////////////////

  // Lowest clear bit wins, searched from the top down
  always_comb begin
    free_found = 1'b0;
    free_id    = '0;
    for (int i = `VSEQ_NR_IDS - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        free_found = 1'b1;
        free_id    = vid_t'(i);
      end
    end
  end

  // IDs still alive after this cycle's completion
  always_comb begin
    done_mask = '0;
    if (done_valid_i) done_mask[done_id_i] = 1'b1;
  end
  assign live_mask = running_q & ~done_mask;

  assign issue_fire_o = insn_valid_i & free_found & unit_ready_i[insn_unit_i] & port_free_i;

  always_comb begin
    running_d = live_mask;
    if (issue_fire_o) running_d[free_id] = 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Access lists and hazards
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    read_list_d  = read_list_q;
    write_list_d = write_list_q;
    // Drop entries of finished IDs, including one finishing now
    for (int v = 0; v < `VSEQ_NR_VREGS; v++) begin
      read_list_d[v].valid  = read_list_q[v].valid & live_mask[read_list_q[v].vid];
      write_list_d[v].valid = write_list_q[v].valid & live_mask[write_list_q[v].vid];
    end

    hazard = '0;
    // RAW on the sources
    if (insn_use_vs1_i && write_list_d[insn_vs1_i].valid)
      hazard[write_list_d[insn_vs1_i].vid] = 1'b1;
    if (insn_use_vs2_i && write_list_d[insn_vs2_i].valid)
      hazard[write_list_d[insn_vs2_i].vid] = 1'b1;
    // WAR and WAW on the destination
    if (insn_use_vd_i && read_list_d[insn_vd_i].valid)
      hazard[read_list_d[insn_vd_i].vid] = 1'b1;
    if (insn_use_vd_i && write_list_d[insn_vd_i].valid)
      hazard[write_list_d[insn_vd_i].vid] = 1'b1;

    // New ID becomes the latest accessor of its registers
    if (issue_fire_o) begin
      if (insn_use_vd_i) write_list_d[insn_vd_i] = '{vid: free_id, valid: 1'b1};
      if (insn_use_vs1_i) read_list_d[insn_vs1_i] = '{vid: free_id, valid: 1'b1};
      if (insn_use_vs2_i) read_list_d[insn_vs2_i] = '{vid: free_id, valid: 1'b1};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q    <= '0;
      read_list_q  <= '0;
      write_list_q <= '0;
    end else begin
      running_q    <= running_d;
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
    end
  end

  // Unit per ID, read back on completion
  always_ff @(posedge clk_i) begin
    if (issue_fire_o) unit_q[free_id] <= insn_unit_i;
  end

  assign issue_unit_o   = insn_unit_i;
  assign issue_id_o     = free_id;
  assign issue_hazard_o = hazard;
  assign done_fire_o    = done_valid_i;
  assign done_unit_o    = unit_q[done_id_i];
  assign idle_o         = ~|running_q;

  // Units only report IDs that were issued and not yet finished
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_valid_i |-> running_q[done_id_i]);

endmodule : hazard_tracker

//--- design/unit_credits.sv
// Queue occupancy of the functional units
// One up/down counter per unit against its configured depth,
// and the mask of units that can take another instruction
`timescale 1ns/100ps
`include "vseq_cfg.svh"

module unit_credits import vseq_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Instruction entering a unit queue
  input  logic       issue_fire_i,
  input  unit_e      issue_unit_i,
  // Instruction leaving a unit queue
  input  logic       done_fire_i,
  input  unit_e      done_unit_i,
  // Units below their depth
  output unit_mask_t unit_ready_o
);

  // Depths in unit_e order
  localparam credit_cnt_t unit_depth [nr_units] = '{
    credit_cnt_t'(`VSEQ_DEPTH_ALU),
    credit_cnt_t'(`VSEQ_DEPTH_MUL),
    credit_cnt_t'(`VSEQ_DEPTH_LOAD),
    credit_cnt_t'(`VSEQ_DEPTH_STORE)
  };

  for (genvar u = 0; u < nr_units; u++) begin : gen_unit_cnt
    credit_cnt_t cnt_q;
    logic        cnt_up;
    logic        cnt_down;

    assign cnt_up   = issue_fire_i && (issue_unit_i == unit_e'(u));
    assign cnt_down = done_fire_i && (done_unit_i == unit_e'(u));

    // Simultaneous issue and done on one unit leave it unchanged
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (cnt_up && !cnt_down) begin
        cnt_q <= cnt_q + 2'd1;
      end else if (cnt_down && !cnt_up) begin
        cnt_q <= cnt_q - 2'd1;
      end
    end

    assign unit_ready_o[u] = (cnt_q < unit_depth[u]);

    // Tracker respects readiness and units return only what they took
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      cnt_q <= unit_depth[u]);
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (cnt_down && !cnt_up) |-> (cnt_q != '0));
  end

endmodule : unit_credits

//--- design/issue_port.sv
// Unit side of the sequencer
// Holds one issued instruction with its ID and hazard vector
// and runs the four-phase sender toward the units
`timescale 1ns/100ps

module issue_port import vseq_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Issue from the tracker
  input  logic     issue_fire_i,
  input  unit_e    issue_unit_i,
  input  vid_t     issue_id_i,
  input  id_mask_t issue_hazard_i,
  input  vreg_t    insn_vd_i,
  input  vreg_t    insn_vs1_i,
  input  vreg_t    insn_vs2_i,
  output logic     port_free_o,
  // Unit handshake
  output logic     unit_req_o,
  output unit_e    unit_sel_o,
  output vid_t     unit_id_o,
  output id_mask_t unit_hazard_o,
  output vreg_t    unit_vd_o,
  output vreg_t    unit_vs1_o,
  output vreg_t    unit_vs2_o,
  input  logic     unit_ack_i
);

  // Free, requesting, or waiting for the ack to drop
  typedef enum logic [1:0] {
    ST_FREE,
    ST_REQ,
    ST_ACK_LOW
  } port_state_e;

  port_state_e state_q, state_d;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_FREE:    if (issue_fire_i) state_d = ST_REQ;
      // Req falls the cycle after ack is seen high
      ST_REQ:     if (unit_ack_i) state_d = ST_ACK_LOW;
      // Free again the cycle after ack is seen low
      ST_ACK_LOW: if (!unit_ack_i) state_d = ST_FREE;
      default:    state_d = ST_FREE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_FREE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_fire_i) begin
      unit_sel_o    <= issue_unit_i;
      unit_id_o     <= issue_id_i;
      unit_hazard_o <= issue_hazard_i;
      unit_vd_o     <= insn_vd_i;
      unit_vs1_o    <= insn_vs1_i;
      unit_vs2_o    <= insn_vs2_i;
    end
  end

  assign port_free_o = (state_q == ST_FREE);
  assign unit_req_o  = (state_q == ST_REQ);

  // Payload is frozen for the whole request phase
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (unit_req_o && $past(unit_req_o)) |->
      $stable({unit_sel_o, unit_id_o, unit_hazard_o, unit_vd_o, unit_vs1_o, unit_vs2_o}));

endmodule : issue_port

//--- design/vector_sequencer.sv
// Vector instruction sequencer, top level
// Intake from the dispatcher, hazard tracker, unit queue credits
// and the issue port toward the functional units
`timescale 1ns/100ps

module vector_sequencer import vseq_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Dispatcher
  input  logic     disp_req_i,
  input  unit_e    disp_unit_i,
  input  vreg_t    disp_vd_i,
  input  vreg_t    disp_vs1_i,
  input  vreg_t    disp_vs2_i,
  input  logic     disp_use_vd_i,
  input  logic     disp_use_vs1_i,
  input  logic     disp_use_vs2_i,
  output logic     disp_ack_o,
  // Functional units
  output logic     unit_req_o,
  output unit_e    unit_sel_o,
  output vid_t     unit_id_o,
  output id_mask_t unit_hazard_o,
  output vreg_t    unit_vd_o,
  output vreg_t    unit_vs1_o,
  output vreg_t    unit_vs2_o,
  input  logic     unit_ack_i,
  // Completion
  input  logic     done_valid_i,
  input  vid_t     done_id_i,
  output logic     idle_o
);

  // Held instruction
  logic       insn_valid;
  unit_e      insn_unit;
  vreg_t      insn_vd, insn_vs1, insn_vs2;
  logic       insn_use_vd, insn_use_vs1, insn_use_vs2;
  // Issue and completion events
  logic       issue_fire, done_fire, port_free;
  unit_e      issue_unit, done_unit;
  vid_t       issue_id;
  id_mask_t   issue_hazard;
  unit_mask_t unit_ready;

  insn_intake i_insn_intake (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .disp_req_i     (disp_req_i),
    .disp_unit_i    (disp_unit_i),
    .disp_vd_i      (disp_vd_i),
    .disp_vs1_i     (disp_vs1_i),
    .disp_vs2_i     (disp_vs2_i),
    .disp_use_vd_i  (disp_use_vd_i),
    .disp_use_vs1_i (disp_use_vs1_i),
    .disp_use_vs2_i (disp_use_vs2_i),
    .disp_ack_o     (disp_ack_o),
    .issue_fire_i   (issue_fire),
    .insn_valid_o   (insn_valid),
    .insn_unit_o    (insn_unit),
    .insn_vd_o      (insn_vd),
    .insn_vs1_o     (insn_vs1),
    .insn_vs2_o     (insn_vs2),
    .insn_use_vd_o  (insn_use_vd),
    .insn_use_vs1_o (insn_use_vs1),
    .insn_use_vs2_o (insn_use_vs2)
  );

  hazard_tracker i_hazard_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_valid_i   (insn_valid),
    .insn_unit_i    (insn_unit),
    .insn_vd_i      (insn_vd),
    .insn_vs1_i     (insn_vs1),
    .insn_vs2_i     (insn_vs2),
    .insn_use_vd_i  (insn_use_vd),
    .insn_use_vs1_i (insn_use_vs1),
    .insn_use_vs2_i (insn_use_vs2),
    .unit_ready_i   (unit_ready),
    .port_free_i    (port_free),
    .done_valid_i   (done_valid_i),
    .done_id_i      (done_id_i),
    .issue_fire_o   (issue_fire),
    .issue_unit_o   (issue_unit),
    .issue_id_o     (issue_id),
    .issue_hazard_o (issue_hazard),
    .done_fire_o    (done_fire),
    .done_unit_o    (done_unit),
    .idle_o         (idle_o)
  );

  unit_credits i_unit_credits (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_fire_i (issue_fire),
    .issue_unit_i (issue_unit),
    .done_fire_i  (done_fire),
    .done_unit_i  (done_unit),
    .unit_ready_o (unit_ready)
  );

  issue_port i_issue_port (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_fire_i   (issue_fire),
    .issue_unit_i   (issue_unit),
    .issue_id_i     (issue_id),
    .issue_hazard_i (issue_hazard),
    .insn_vd_i      (insn_vd),
    .insn_vs1_i     (insn_vs1),
    .insn_vs2_i     (insn_vs2),
    .port_free_o    (port_free),
    .unit_req_o     (unit_req_o),
    .unit_sel_o     (unit_sel_o),
    .unit_id_o      (unit_id_o),
    .unit_hazard_o  (unit_hazard_o),
    .unit_vd_o      (unit_vd_o),
    .unit_vs1_o     (unit_vs1_o),
    .unit_vs2_o     (unit_vs2_o),
    .unit_ack_i     (unit_ack_i)
  );

endmodule : vector_sequencer

//--- tests/tb_vector_sequencer.sv
// Testbench of the vector sequencer
// Clock and reset, a dispatcher driver fed from the test data file,
// a unit responder with random ack delays, value checks and a timeout
`timescale 1ns/100ps

module tb_vector_sequencer import vseq_pkg::*; ();

  logic     clk_i, rst_ni;
  logic     disp_req_i, disp_ack_o;
  unit_e    disp_unit_i;
  vreg_t    disp_vd_i, disp_vs1_i, disp_vs2_i;
  logic     disp_use_vd_i, disp_use_vs1_i, disp_use_vs2_i;
  logic     unit_req_o, unit_ack_i;
  unit_e    unit_sel_o;
  vid_t     unit_id_o;
  id_mask_t unit_hazard_o;
  vreg_t    unit_vd_o, unit_vs1_o, unit_vs2_o;
  logic     done_valid_i, idle_o;
  vid_t     done_id_i;

  // Expected issue results, in dispatch order
  int exp_unit_q[$];
  int exp_id_q[$];
  int exp_haz_q[$];
  // Register fields forwarded to the unit
  int exp_vd_q[$];
  int exp_vs1_q[$];
  int exp_vs2_q[$];

  // Fields of the current data line
  int f_unit, f_vd, f_vs1, f_vs2, f_use_vd, f_use_vs1, f_use_vs2, f_id, f_haz;
  int fd, nr_lines;
  logic [7:0] cmd;
  logic [8*128-1:0] line_buf;
  logic stall_next, pending;
  int cycle_cnt = 0;
  int cycle_limit = 0;

  vector_sequencer i_vector_sequencer (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Run limit scales with the number of data lines
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "Timeout, the run did not finish within %0d cycles", cycle_limit);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Drive point, just after the rising edge
  task automatic step();
    @(posedge clk_i);
    #0.5;
  endtask

  task automatic check_eq(input int got, input int exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic open_testdata(output int handle);
    handle = $fopen("tests/vseq_testdata.txt", "r");
    if (handle == 0) begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "Cannot open the test data file tests/vseq_testdata.txt");
    end
  endtask

  task automatic report_bad_line();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Malformed line in the test data file");
  endtask

  // Sampled at the falling edge, away from the responder's drive point
  task automatic wait_port_idle();
    do @(negedge clk_i); while (unit_req_o || unit_ack_i || exp_unit_q.size() != 0);
    step();
  endtask

  // Ack phase of the dispatcher handshake
  task automatic finish_handshake();
    do step(); while (!disp_ack_o);
    disp_req_i = 1'b0;
    do step(); while (disp_ack_o);
    pending = 1'b0;
  endtask

  task automatic pulse_done(input int id);
    done_valid_i = 1'b1;
    done_id_i    = vid_t'(id);
    step();
    done_valid_i = 1'b0;
  endtask

  task automatic dispatch_insn();
    // A stalled instruction must not hide behind an earlier request
    if (stall_next) wait_port_idle();
    exp_unit_q.push_back(f_unit);
    exp_id_q.push_back(f_id);
    exp_haz_q.push_back(f_haz);
    exp_vd_q.push_back(f_vd);
    exp_vs1_q.push_back(f_vs1);
    exp_vs2_q.push_back(f_vs2);
    disp_unit_i    = unit_e'(f_unit[1:0]);
    disp_vd_i      = vreg_t'(f_vd);
    disp_vs1_i     = vreg_t'(f_vs1);
    disp_vs2_i     = vreg_t'(f_vs2);
    disp_use_vd_i  = (f_use_vd != 0);
    disp_use_vs1_i = (f_use_vs1 != 0);
    disp_use_vs2_i = (f_use_vs2 != 0);
    disp_req_i     = 1'b1;
    if (stall_next) begin
      repeat (16) begin
        step();
        check_eq(32'(unit_req_o), 0, "unit_req_o of a stalled instruction");
        check_eq(32'(disp_ack_o), 0, "disp_ack_o of a stalled instruction");
      end
      // Req stays high, a later done completes the handshake
      stall_next = 1'b0;
      pending    = 1'b1;
    end else begin
      finish_handshake();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Unit responder
  ////////////////////////////////////////////////////////////////////////////

  initial begin : unit_responder
    int delay;
    forever begin
      step();
      if (unit_req_o) begin
        if (exp_unit_q.size() == 0) begin
          $display("TEST RESULT: FAIL");
          $fatal(1, "Unit request arrived with no instruction dispatched");
        end
        check_eq(32'(unit_sel_o), exp_unit_q.pop_front(), "unit_sel_o");
        check_eq(32'(unit_id_o), exp_id_q.pop_front(), "unit_id_o");
        check_eq(32'(unit_hazard_o), exp_haz_q.pop_front(), "unit_hazard_o");
        check_eq(32'(unit_vd_o), exp_vd_q.pop_front(), "unit_vd_o");
        check_eq(32'(unit_vs1_o), exp_vs1_q.pop_front(), "unit_vs1_o");
        check_eq(32'(unit_vs2_o), exp_vs2_q.pop_front(), "unit_vs2_o");
        delay = int'($urandom % 4);
        // Req holds until the ack comes
        repeat (delay) begin
          step();
          check_eq(32'(unit_req_o), 1, "unit_req_o before ack");
        end
        unit_ack_i = 1'b1;
        do step(); while (unit_req_o);
        unit_ack_i = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Command stream
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main_flow
    void'($urandom(32'h7825d84f));
    rst_ni         = 1'b0;
    disp_req_i     = 1'b0;
    disp_unit_i    = UNIT_ALU;
    disp_vd_i      = '0;
    disp_vs1_i     = '0;
    disp_vs2_i     = '0;
    disp_use_vd_i  = 1'b0;
    disp_use_vs1_i = 1'b0;
    disp_use_vs2_i = 1'b0;
    unit_ack_i     = 1'b0;
    done_valid_i   = 1'b0;
    done_id_i      = '0;
    stall_next     = 1'b0;
    pending        = 1'b0;
    nr_lines       = 0;

    // First pass sizes the timeout
    open_testdata(fd);
    while ($fgets(line_buf, fd) != 0) nr_lines++;
    $fclose(fd);
    cycle_limit = 64 * nr_lines;

    repeat (2) @(posedge clk_i);
    #0.5;
    rst_ni = 1'b1;
    check_eq(32'(idle_o), 1, "idle_o after reset");

    open_testdata(fd);
    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd == "#") begin
        void'($fgets(line_buf, fd));
      end else if (cmd == "N") begin
        stall_next = 1'b1;
      end else if (cmd == "D") begin
        if ($fscanf(fd, "%d", f_id) != 1) report_bad_line();
        pulse_done(f_id);
        if (pending) finish_handshake();
      end else if (cmd == "I") begin
        if ($fscanf(fd, "%d %d %d %d %d %d %d %d %b", f_unit, f_vd, f_vs1, f_vs2,
                    f_use_vd, f_use_vs1, f_use_vs2, f_id, f_haz) != 9) report_bad_line();
        dispatch_insn();
      end else begin
        report_bad_line();
      end
    end
    $fclose(fd);

    // Every ID finished and every request answered
    wait_port_idle();
    step();
    check_eq(32'(idle_o), 1, "idle_o at the end");
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule : tb_vector_sequencer

//--- tests/vseq_testdata.txt
# I unit vd vs1 vs2 use_vd use_vs1 use_vs2 exp_id exp_hazard, the hazard in binary
# D id completes an ID, N makes the next I stall until a later D releases it
# Load, then RAW on vs1, WAR on vd and WAW on vd
I 2  1  0  0 1 0 0 0 0000
I 0  2  1  3 1 1 1 1 0001
I 0  3  4  5 1 1 1 2 0010
I 1  2  6  7 1 1 1 3 0010
# All four IDs running, the MUL waits for a free ID and reuses ID 1
N
I 1  8  9 10 1 1 1 1 0000
D 1
# Done of the load removes its RAW hazard on v1
D 0
I 0 11  1  0 1 1 0 0 0000
D 2
D 3
# Load depth is 1, the second load waits although ID 3 is free
I 2 12  0  0 1 0 0 2 0000
N
I 2 13  0  0 1 0 0 2 0000
D 2
# RAW on vs2 only, then RAW and WAW from two IDs
I 3  0 12 13 0 1 1 3 0100
D 3
I 0  8 11  0 1 1 0 3 0011
D 0
D 1
D 2
D 3

//--- sources.f
+incdir+design
design/vseq_pkg.sv
design/insn_intake.sv
design/hazard_tracker.sv
design/unit_credits.sv
design/issue_port.sv
design/vector_sequencer.sv
tests/tb_vector_sequencer.sv

//--- Makefile
TOP = tb_vector_sequencer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
